// File: src/lsu_pkg.sv
/* Load/store unit shared definitions */

`default_nettype none

package lsu_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // RV32 data and address width
    localparam int xlen       = 32;
    localparam int strb_w     = xlen / 8;
    localparam int reg_addr_w = 5;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Major opcodes handled by the unit
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } lsu_opcode_e;

    // Access size and sign, stores use the first three only
    typedef enum logic [2:0] {
        f3_byte   = 3'd0,
        f3_half   = 3'd1,
        f3_word   = 3'd2,
        f3_byte_u = 3'd4,
        f3_half_u = 3'd5
    } lsu_funct3_e;

    typedef enum logic [2:0] {
        st_idle,
        st_rd_addr,
        st_rd_data,
        st_wr_req,
        st_wr_resp
    } lsu_state_e;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    // Decoded memory request
    typedef struct packed {
        logic                  is_store;
        lsu_funct3_e           funct3;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       addr;
    } lsu_req_t;

    // AXI4-lite signals driven by the master
    typedef struct packed {
        logic              awvalid;
        logic [xlen-1:0]   awaddr;
        logic              wvalid;
        logic [xlen-1:0]   wdata;
        logic [strb_w-1:0] wstrb;
        logic              bready;
        logic              arvalid;
        logic [xlen-1:0]   araddr;
        logic              rready;
    } axi_mst_t;

    // AXI4-lite signals driven by the memory
    typedef struct packed {
        logic            awready;
        logic            wready;
        logic            bvalid;
        logic [1:0]      bresp;
        logic            arready;
        logic            rvalid;
        logic [1:0]      rresp;
        logic [xlen-1:0] rdata;
    } axi_slv_t;

    // Register file write port
    typedef struct packed {
        logic                  wr;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       val;
    } rd_wr_t;

endpackage

`default_nettype wire

// File: src/lsu_decode.sv
/* Load/store instruction decode */

`timescale 1ns/1ps
`default_nettype none

module lsu_decode (
    input  logic [lsu_pkg::xlen-1:0]       instr,
    output logic [lsu_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [lsu_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [lsu_pkg::xlen-1:0]       rs1_val,
    output lsu_pkg::lsu_req_t              req,
    output logic                           is_mem_op,
    output logic                           misaligned
);
    import lsu_pkg::*;

    lsu_opcode_e     opcode;
    lsu_funct3_e     funct3;
    logic [11:0]     imm_i;
    logic [11:0]     imm_s;
    logic [11:0]     imm;
    logic [xlen-1:0] addr;

    //////////////////////////////
    // Instruction fields
    //////////////////////////////

    assign opcode   = lsu_opcode_e'(instr[6:0]);
    assign funct3   = lsu_funct3_e'(instr[14:12]);
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // I-type for loads, S-type splits the offset around rd
    assign imm_i = instr[31:20];
    assign imm_s = {instr[31:25], instr[11:7]};
    assign imm   = (opcode == op_store) ? imm_s : imm_i;

    // Effective address
    assign addr = rs1_val + {{(xlen-12){imm[11]}}, imm};

    assign is_mem_op = (opcode == op_load) || (opcode == op_store);

    //////////////////////////////
    // Alignment check
    //////////////////////////////

    always_comb begin
        misaligned = 1'b0;
        case (funct3)
            // Halfwords need an even address
            f3_half, f3_half_u: misaligned = addr[0];
            f3_word:            misaligned = |addr[1:0];
            default:            misaligned = 1'b0;
        endcase
        // Only memory ops can fault
        misaligned = misaligned & is_mem_op;
    end

    assign req = '{is_store: (opcode == op_store), funct3: funct3, rd: instr[11:7], addr: addr};

endmodule

`default_nettype wire

// File: src/lsu_store_align.sv
/* Store lane placement */

`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
    input  lsu_pkg::lsu_funct3_e         funct3,
    input  logic [1:0]                   offset,
    input  logic [lsu_pkg::xlen-1:0]     rs2_val,
    output logic [lsu_pkg::xlen-1:0]     wdata,
    output logic [lsu_pkg::strb_w-1:0]   wstrb
);
    import lsu_pkg::*;

    logic [strb_w-1:0] base_strb;
    logic [4:0]        bit_shift;

    // Byte offset scaled to a bit shift
    assign bit_shift = {offset, 3'b000};

    //////////////////////////////
    // Data lanes
    //////////////////////////////

    // Low bytes of rs2 move up into the addressed lanes
    assign wdata = rs2_val << bit_shift;

    //////////////////////////////
    // Strobes
    //////////////////////////////

    always_comb begin
        case (funct3)
            f3_byte, f3_byte_u: base_strb = 4'b0001;
            f3_half, f3_half_u: base_strb = 4'b0011;
            // Word and anything else writes all lanes
            default:            base_strb = 4'b1111;
        endcase
    end

    // Same offset as the data
    assign wstrb = base_strb << offset;

endmodule

`default_nettype wire

// File: src/lsu_load_format.sv
/* Load data extraction */

`timescale 1ns/1ps
`default_nettype none

module lsu_load_format (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           rd_accept,
    input  lsu_pkg::lsu_funct3_e           funct3,
    input  logic [1:0]                     offset,
    input  logic [lsu_pkg::reg_addr_w-1:0] rd,
    input  logic [lsu_pkg::xlen-1:0]       rdata,
    output lsu_pkg::rd_wr_t                rd_wr
);
    import lsu_pkg::*;

    logic [xlen-1:0]       shifted;
    logic [xlen-1:0]       ext_val;
    logic                  wr_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [xlen-1:0]       val_q;

    //////////////////////////////
    // Extraction
    //////////////////////////////

    // Addressed byte lands in bit 0
    assign shifted = rdata >> {offset, 3'b000};

    always_comb begin
        case (funct3)
            f3_byte:   ext_val = {{(xlen-8){shifted[7]}}, shifted[7:0]};
            f3_byte_u: ext_val = {{(xlen-8){1'b0}}, shifted[7:0]};
            f3_half:   ext_val = {{(xlen-16){shifted[15]}}, shifted[15:0]};
            f3_half_u: ext_val = {{(xlen-16){1'b0}}, shifted[15:0]};
            default:   ext_val = shifted;
        endcase
    end

    //////////////////////////////
    // RD write
    //////////////////////////////

    // One cycle pulse after the R handshake
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= rd_accept;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_accept) begin
            rd_q  <= rd;
            val_q <= ext_val;
        end
    end

    assign rd_wr = '{wr: wr_q, addr: rd_q, val: val_q};

endmodule

`default_nettype wire

// File: src/lsu_ctrl.sv
/* Load/store control FSM */

`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           instr_valid,
    output logic                           instr_ready,
    input  lsu_pkg::lsu_req_t              req,
    input  logic                           is_mem_op,
    input  logic                           misaligned,
    input  logic [lsu_pkg::xlen-1:0]       wdata,
    input  logic [lsu_pkg::strb_w-1:0]     wstrb,
    output lsu_pkg::axi_mst_t              axi_m,
    input  lsu_pkg::axi_slv_t              axi_s,
    output lsu_pkg::lsu_funct3_e           held_funct3,
    output logic [1:0]                     held_offset,
    output logic [lsu_pkg::reg_addr_w-1:0] held_rd,
    output logic                           rd_accept,
    output logic [1:0]                     exceptions
);
    import lsu_pkg::*;

    lsu_state_e        state;
    lsu_req_t          req_q;
    logic [xlen-1:0]   wdata_q;
    logic [strb_w-1:0] wstrb_q;
    logic              ready_q;
    logic              awvalid_q;
    logic              wvalid_q;
    logic              bready_q;
    logic              arvalid_q;
    logic              rready_q;
    logic              accept;
    logic              start;
    logic              aw_done;
    logic              w_done;

    assign accept = instr_valid && instr_ready;
    // Aligned memory ops go to the bus, everything else is dropped
    assign start  = accept && is_mem_op && !misaligned;

    // A channel is done once ready is seen or it was already taken
    assign aw_done = !awvalid_q || axi_s.awready;
    assign w_done  = !wvalid_q || axi_s.wready;

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= st_idle;
            ready_q   <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            bready_q  <= 1'b0;
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    ready_q <= 1'b1;
                    if (start) begin
                        ready_q <= 1'b0;
                        if (req.is_store) begin
                            // AW and W raised together
                            awvalid_q <= 1'b1;
                            wvalid_q  <= 1'b1;
                            state     <= st_wr_req;
                        end else begin
                            arvalid_q <= 1'b1;
                            state     <= st_rd_addr;
                        end
                    end
                end
                st_rd_addr: begin
                    if (axi_s.arready) begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                        state     <= st_rd_data;
                    end
                end
                st_rd_data: begin
                    if (axi_s.rvalid) begin
                        rready_q <= 1'b0;
                        ready_q  <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_wr_req: begin
                    if (axi_s.awready) awvalid_q <= 1'b0;
                    if (axi_s.wready) wvalid_q <= 1'b0;
                    // Response only after both halves are taken
                    if (aw_done && w_done) begin
                        bready_q <= 1'b1;
                        state    <= st_wr_resp;
                    end
                end
                st_wr_resp: begin
                    if (axi_s.bvalid) begin
                        bready_q <= 1'b0;
                        ready_q  <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request payload held for the whole transfer
    always_ff @(posedge aclk) begin
        if (start) begin
            req_q   <= req;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign instr_ready = ready_q;

    assign axi_m = '{awvalid: awvalid_q, awaddr: req_q.addr, wvalid: wvalid_q,
                     wdata: wdata_q, wstrb: wstrb_q, bready: bready_q,
                     arvalid: arvalid_q, araddr: req_q.addr, rready: rready_q};

    assign held_funct3 = req_q.funct3;
    assign held_offset = req_q.addr[1:0];
    assign held_rd     = req_q.rd;

    // R handshake
    assign rd_accept = (state == st_rd_data) && rready_q && axi_s.rvalid;

    // Bit 0 load, bit 1 store
    assign exceptions[0] = accept && misaligned && !req.is_store;
    assign exceptions[1] = accept && misaligned && req.is_store;

endmodule

`default_nettype wire

// File: src/lsu_top.sv
/* Load/store unit */

`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                           aclk,
    input  logic                           aresetn,
    // Instruction handshake
    input  logic                           instr_valid,
    output logic                           instr_ready,
    input  logic [lsu_pkg::xlen-1:0]       instr,
    output logic [1:0]                     exceptions,
    // Register file
    output logic [lsu_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [lsu_pkg::xlen-1:0]       rs1_val,
    output logic [lsu_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [lsu_pkg::xlen-1:0]       rs2_val,
    output lsu_pkg::rd_wr_t                rd_wr,
    // AXI4-lite master
    output lsu_pkg::axi_mst_t              axi_m,
    input  lsu_pkg::axi_slv_t              axi_s
);
    import lsu_pkg::*;

    lsu_req_t              req;
    logic                  is_mem_op;
    logic                  misaligned;
    logic [xlen-1:0]       wdata;
    logic [strb_w-1:0]     wstrb;
    lsu_funct3_e           held_funct3;
    logic [1:0]            held_offset;
    logic [reg_addr_w-1:0] held_rd;
    logic                  rd_accept;

    //////////////////////////////
    // Decode and store lanes
    //////////////////////////////

    lsu_decode i_decode (
        .instr      (instr),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_val    (rs1_val),
        .req        (req),
        .is_mem_op  (is_mem_op),
        .misaligned (misaligned)
    );

    lsu_store_align i_store_align (
        .funct3  (req.funct3),
        .offset  (req.addr[1:0]),
        .rs2_val (rs2_val),
        .wdata   (wdata),
        .wstrb   (wstrb)
    );

    //////////////////////////////
    // Control and load return
    //////////////////////////////

    lsu_ctrl i_ctrl (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .req         (req),
        .is_mem_op   (is_mem_op),
        .misaligned  (misaligned),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .axi_m       (axi_m),
        .axi_s       (axi_s),
        .held_funct3 (held_funct3),
        .held_offset (held_offset),
        .held_rd     (held_rd),
        .rd_accept   (rd_accept),
        .exceptions  (exceptions)
    );

    // Uses the request held by the FSM
    lsu_load_format i_load_format (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .rd_accept (rd_accept),
        .funct3    (held_funct3),
        .offset    (held_offset),
        .rd        (held_rd),
        .rdata     (axi_s.rdata),
        .rd_wr     (rd_wr)
    );

endmodule

`default_nettype wire

// File: dv/lsu_chk.sv
/* LSU protocol checks */

`timescale 1ns/1ps
`default_nettype none

module lsu_chk (
    input logic               aclk,
    input logic               aresetn,
    input logic               instr_valid,
    input logic               instr_ready,
    input logic [1:0]         exceptions,
    input lsu_pkg::rd_wr_t    rd_wr,
    input lsu_pkg::axi_mst_t  axi_m,
    input lsu_pkg::axi_slv_t  axi_s
);
    // Read by the testbench at the end of the run
    int fail_count = 0;

    //////////////////////////////
    // AXI valid hold
    //////////////////////////////

    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        axi_m.awvalid && !axi_s.awready |=> axi_m.awvalid && $stable(axi_m.awaddr))
    else begin
        $error("awvalid dropped or awaddr changed before awready");
        fail_count++;
    end

    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        axi_m.wvalid && !axi_s.wready |=>
        axi_m.wvalid && $stable(axi_m.wdata) && $stable(axi_m.wstrb))
    else begin
        $error("wvalid dropped or write data changed before wready");
        fail_count++;
    end

    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        axi_m.arvalid && !axi_s.arready |=> axi_m.arvalid && $stable(axi_m.araddr))
    else begin
        $error("arvalid dropped or araddr changed before arready");
        fail_count++;
    end

    //////////////////////////////
    // Core side
    //////////////////////////////

    // Register write is a single cycle pulse
    wr_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr.wr |=> !rd_wr.wr)
    else begin
        $error("rd_wr.wr held for more than one cycle");
        fail_count++;
    end

    // Faults only on accept and start no transfer
    exc_accept: assert property (@(posedge aclk) disable iff (!aresetn)
        exceptions != 2'b00 |-> (instr_valid && instr_ready) ##1
        (instr_ready && !axi_m.awvalid && !axi_m.wvalid && !axi_m.arvalid))
    else begin
        $error("exception bit set without an accepted instruction or a transfer started");
        fail_count++;
    end

endmodule

bind lsu_top lsu_chk i_chk (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .exceptions  (exceptions),
    .rd_wr       (rd_wr),
    .axi_m       (axi_m),
    .axi_s       (axi_s)
);

`default_nettype wire

// File: dv/lsu_tb.sv
/* LSU testbench */

`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    // 69 instructions over all tests
    localparam int num_instr    = 69;
    localparam int reset_cycles = 4;
    localparam int cycle_limit  = 20 * num_instr + reset_cycles;
    // Load and store mix for the random test, entries 5 to 7 are stores
    localparam logic [2:0] op_f3 [8] = '{f3_byte, f3_half, f3_word, f3_byte_u,
                                         f3_half_u, f3_byte, f3_half, f3_word};

    logic                  aclk;
    logic                  aresetn;
    logic                  instr_valid;
    logic                  instr_ready;
    logic [xlen-1:0]       instr;
    logic [1:0]            exceptions;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    rd_wr_t                rd_wr;
    axi_mst_t              axi_m;
    axi_slv_t              axi_s;

    logic [xlen-1:0] rf [32];
    logic [xlen-1:0] mem [64];
    // Expected memory contents, built from the store rules
    logic [xlen-1:0] ref_mem [64];

    // Memory model state
    logic              aw_got;
    logic              w_got;
    logic              b_pend;
    logic              r_pend;
    logic [xlen-1:0]   aw_addr;
    logic [xlen-1:0]   r_addr;
    logic [xlen-1:0]   w_data;
    logic [strb_w-1:0] w_strb;
    logic [1:0]        aw_dly;
    logic [1:0]        w_dly;
    logic [1:0]        ar_dly;
    logic [1:0]        r_dly;
    logic [1:0]        b_dly;
    logic [31:0]       rnd;

    int    seed   = 32'h6bbfb48c;
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    err_mark;
    int    chk_mark;
    string test_name;

    always #20 aclk = ~aclk;

    lsu_top i_dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .exceptions  (exceptions),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .rs2_addr    (rs2_addr),
        .rs2_val     (rs2_val),
        .rd_wr       (rd_wr),
        .axi_m       (axi_m),
        .axi_s       (axi_s)
    );

    //////////////////////////////
    // Register file and memory
    //////////////////////////////

    // x0 never written
    always @(posedge aclk) begin
        if (rd_wr.wr && rd_wr.addr != 0)
            rf[rd_wr.addr] <= rd_wr.val;
    end

    assign rs1_val = rf[rs1_addr];
    assign rs2_val = rf[rs2_addr];

    // Each ready or response waits 0 to 3 cycles
    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            axi_s  <= '0;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            b_pend <= 1'b0;
            r_pend <= 1'b0;
            aw_dly <= '0;
            w_dly  <= '0;
            ar_dly <= '0;
            r_dly  <= '0;
            b_dly  <= '0;
        end else begin
            rnd = $random(seed);
            axi_s.awready <= 1'b0;
            axi_s.wready  <= 1'b0;
            axi_s.arready <= 1'b0;
            // Write address
            if (axi_m.awvalid && !axi_s.awready) begin
                if (aw_dly == 0)
                    axi_s.awready <= 1'b1;
                else
                    aw_dly <= aw_dly - 1'b1;
            end
            if (axi_m.awvalid && axi_s.awready) begin
                aw_got  <= 1'b1;
                aw_addr <= axi_m.awaddr;
                aw_dly  <= rnd[1:0];
            end
            // Write data
            if (axi_m.wvalid && !axi_s.wready) begin
                if (w_dly == 0)
                    axi_s.wready <= 1'b1;
                else
                    w_dly <= w_dly - 1'b1;
            end
            if (axi_m.wvalid && axi_s.wready) begin
                w_got  <= 1'b1;
                w_data <= axi_m.wdata;
                w_strb <= axi_m.wstrb;
                w_dly  <= rnd[3:2];
            end
            // Merge once both halves are in
            if (aw_got && w_got) begin
                for (int i = 0; i < strb_w; i++) begin
                    if (w_strb[i])
                        mem[aw_addr[7:2]][8*i +: 8] <= w_data[8*i +: 8];
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
                b_dly  <= rnd[5:4];
            end
            if (b_pend) begin
                if (b_dly == 0) begin
                    axi_s.bvalid <= 1'b1;
                    b_pend       <= 1'b0;
                end else begin
                    b_dly <= b_dly - 1'b1;
                end
            end
            if (axi_s.bvalid && axi_m.bready)
                axi_s.bvalid <= 1'b0;
            // Read address, then data
            if (axi_m.arvalid && !axi_s.arready) begin
                if (ar_dly == 0)
                    axi_s.arready <= 1'b1;
                else
                    ar_dly <= ar_dly - 1'b1;
            end
            if (axi_m.arvalid && axi_s.arready) begin
                r_pend <= 1'b1;
                r_addr <= axi_m.araddr;
                ar_dly <= rnd[7:6];
                r_dly  <= rnd[9:8];
            end
            if (r_pend) begin
                if (r_dly == 0) begin
                    axi_s.rvalid <= 1'b1;
                    axi_s.rdata  <= mem[r_addr[7:2]];
                    r_pend       <= 1'b0;
                end else begin
                    r_dly <= r_dly - 1'b1;
                end
            end
            if (axi_s.rvalid && axi_m.rready)
                axi_s.rvalid <= 1'b0;
        end
    end

    // Run limit
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////
    // Expected values
    //////////////////////////////

    function automatic logic [5:0] activity();
        return {axi_m.awvalid, axi_m.wvalid, axi_m.arvalid,
                axi_m.bready, axi_m.rready, rd_wr.wr};
    endfunction

    function automatic logic [3:0] strobe_expect(input logic [2:0] f3);
        case (f3[1:0])
            2'd0:    return 4'b0001;
            2'd1:    return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // Pick the addressed byte or half, then extend by funct3
    function automatic logic [31:0] load_expect(input logic [2:0] f3,
                                                input logic [31:0] word,
                                                input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            3'd0:    return {{24{b[7]}}, b};
            3'd4:    return {24'd0, b};
            3'd1:    return {{16{h[15]}}, h};
            3'd5:    return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("** Error %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
        chk_mark  = checks;
    endtask

    task automatic finish_test();
        $display("test %s done: %0d checks, %0d errors",
                 test_name, checks - chk_mark, errors - err_mark);
    endtask

    //////////////////////////////
    // Instruction driver
    //////////////////////////////

    // x1 holds the base and x2 the store data, imm is a random small offset
    task automatic run_instr(input logic is_store, input logic [2:0] f3,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic [4:0] rd);
        logic [31:0] r;
        logic [11:0] imm;
        logic [1:0]  exp_exc;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [5:0]  idx;
        logic        bad;
        r       = $random(seed);
        imm     = {{6{r[5]}}, r[5:0]};
        idx     = addr[7:2];
        bad     = (f3[1:0] == 2'd1 && addr[0]) || (f3[1:0] == 2'd2 && addr[1:0] != 2'd0);
        exp_exc = bad ? (is_store ? 2'b10 : 2'b01) : 2'b00;
        @(posedge aclk);
        rf[1]       <= addr - {{20{imm[11]}}, imm};
        rf[2]       <= data;
        instr       <= is_store ? {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011}
                                : {imm, 5'd1, f3, rd, 7'b0000011};
        instr_valid <= 1'b1;
        // Accept on the edge after ready is seen
        do @(negedge aclk); while (!instr_ready);
        compare("exceptions", exp_exc, exceptions);
        @(posedge aclk);
        instr_valid <= 1'b0;
        @(negedge aclk);
        if (bad) begin
            compare("bus after fault", 0, activity());
            compare("instr_ready after fault", 1, instr_ready);
        end else if (is_store) begin
            strb  = strobe_expect(f3) << addr[1:0];
            wdata = data << (8 * addr[1:0]);
            for (int i = 0; i < 4; i++) begin
                if (strb[i])
                    ref_mem[idx][8*i +: 8] = wdata[8*i +: 8];
            end
            while (!instr_ready) @(negedge aclk);
            compare("wstrb", strb, w_strb);
            compare("wdata", wdata, w_data);
            compare("memory word", ref_mem[idx], mem[idx]);
        end else begin
            while (!rd_wr.wr) @(negedge aclk);
            compare("rd index", rd, rd_wr.addr);
            compare("load value", load_expect(f3, ref_mem[idx], addr[1:0]), rd_wr.val);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    initial begin
        int          n;
        int          total;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [1:0]  off;
        logic [4:0]  rd_r;
        aclk        = 1'b0;
        aresetn     <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        axi_s       <= '0;
        rf[0]       <= '0;
        for (n = 1; n < 32; n++)
            rf[n] <= $random(seed);
        for (n = 0; n < 64; n++) begin
            r          = $random(seed);
            mem[n]     <= r;
            ref_mem[n] = r;
        end

        begin_test("reset");
        repeat (reset_cycles - 1) @(posedge aclk);
        @(negedge aclk);
        compare("outputs in reset", 0, {instr_ready, activity()});
        @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        @(negedge aclk);
        compare("instr_ready after reset", 1, instr_ready);
        compare("bus after reset", 0, activity());
        finish_test();

        begin_test("sw_lw");
        run_instr(1'b1, f3_word, 32'h40, $random(seed), 5'd0);
        run_instr(1'b0, f3_word, 32'h40, 32'd0, 5'd7);
        finish_test();

        begin_test("sb_sh");
        for (n = 0; n < 4; n++)
            run_instr(1'b1, f3_byte, 32'h80 + n, $random(seed), 5'd0);
        run_instr(1'b1, f3_half, 32'h90, $random(seed), 5'd0);
        run_instr(1'b1, f3_half, 32'h92, $random(seed), 5'd0);
        finish_test();

        begin_test("loads");
        for (n = 0; n < 4; n++) begin
            run_instr(1'b0, f3_byte, 32'h80 + n, 32'd0, 5'd8 + n);
            run_instr(1'b0, f3_byte_u, 32'h80 + n, 32'd0, 5'd12 + n);
        end
        for (n = 0; n < 4; n += 2) begin
            run_instr(1'b0, f3_half, 32'h90 + n, 32'd0, 5'd16 + n);
            run_instr(1'b0, f3_half_u, 32'h90 + n, 32'd0, 5'd17 + n);
        end
        finish_test();

        begin_test("misaligned");
        run_instr(1'b0, f3_half, 32'h21, 32'd0, 5'd9);
        run_instr(1'b0, f3_half_u, 32'h23, 32'd0, 5'd9);
        for (n = 1; n < 4; n++) begin
            run_instr(1'b0, f3_word, 32'h20 + n, 32'd0, 5'd10);
            run_instr(1'b1, f3_word, 32'h24 + n, $random(seed), 5'd0);
        end
        run_instr(1'b1, f3_half, 32'h29, $random(seed), 5'd0);
        finish_test();

        // Mixed aligned accesses under back-pressure
        begin_test("random");
        for (n = 0; n < 40; n++) begin
            r    = $random(seed);
            f3   = op_f3[r[2:0]];
            off  = (f3[1:0] == 2'd0) ? r[4:3] : (f3[1:0] == 2'd1) ? {r[3], 1'b0} : 2'd0;
            rd_r = r[15:11] % 29 + 3;
            run_instr(r[2:0] >= 3'd5, f3, {24'd0, r[10:5], off}, $random(seed), rd_r);
        end
        finish_test();

        total = errors + i_dut.i_chk.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_dut.i_chk.fail_count);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu_top.f
src/lsu_pkg.sv
src/lsu_decode.sv
src/lsu_store_align.sv
src/lsu_load_format.sv
src/lsu_ctrl.sv
src/lsu_top.sv
dv/lsu_chk.sv
dv/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - src/lsu_pkg.sv
  - src/lsu_decode.sv
  - src/lsu_store_align.sv
  - src/lsu_load_format.sv
  - src/lsu_ctrl.sv
  - src/lsu_top.sv
  - target: test
    files:
      - dv/lsu_chk.sv
      - dv/lsu_tb.sv
